/* common/l2_axi_if.sv */
/*
 * single-beat AXI-lite style channels, byte addresses
 * no ids, no response codes, aw and w are issued together
 */
`timescale 1ns/100ps

interface l2_axi_if;

    // read address and data
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic        rvalid;
    logic        rready;

    // write address and data
    logic [31:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;

    // write response
    logic        bvalid;
    logic        bready;

    modport master (
        output araddr, arvalid, rready,
        output awaddr, awvalid, wdata, wstrb, wvalid, bready,
        input  arready, rdata, rvalid, awready, wready, bvalid
    );

    modport slave (
        input  araddr, arvalid, rready,
        input  awaddr, awvalid, wdata, wstrb, wvalid, bready,
        output arready, rdata, rvalid, awready, wready, bvalid
    );

endinterface

/* common/l2_sim_params.svh */
/*
 * latencies must be at least 1 and the queue depth a power of two
 * the UART word address must lie outside the memory range
 */
`ifndef L2_SIM_PARAMS_SVH
`define L2_SIM_PARAMS_SVH

// requester side
`define L2_SIM_NUM_PORTS 2
`define L2_SIM_SUB_ID_W 2
`define L2_SIM_REQ_DEPTH 4

// memory model, word count must be a power of two
`define L2_SIM_MEM_WORDS 256

// cycles from acceptance to rvalid / bvalid, minus one
`define L2_SIM_READ_LATENCY 5
`define L2_SIM_WRITE_LATENCY 5

// console word address
`define L2_SIM_UART_ADDR 30'h400

`endif

/* common/l2_sim_pkg.sv */
/*
 * shared request and state types
 * addresses are 30-bit word addresses, no bursts, no atomics
 */
`include "l2_sim_params.svh"

package l2_sim_pkg;

    ////////////////////
    // request types

    typedef enum logic {
        L2_READ,
        L2_WRITE
    } l2_op_t;

    typedef logic [`L2_SIM_SUB_ID_W-1:0] l2_sub_id_t;
    typedef logic [$clog2(`L2_SIM_NUM_PORTS)-1:0] l2_port_t;

    // one queued request, write data travels with it
    typedef struct packed {
        l2_op_t     op;
        logic [29:0] addr;
        logic [3:0] be;
        logic [31:0] wr_data;
        l2_sub_id_t sub_id;
        // stamped by the arbiter
        l2_port_t   port;
    } l2_request_t;

    ////////////////////
    // state machines

    typedef enum logic [1:0] {
        BR_IDLE,
        BR_READ,
        BR_WRITE,
        BR_RETURN
    } bridge_state_t;

    typedef enum logic [1:0] {
        MEM_IDLE,
        MEM_WAIT,
        MEM_RESPOND
    } mem_state_t;

endpackage

/* l2_sim.f */
+incdir+common
common/l2_sim_pkg.sv
common/l2_axi_if.sv
rtl/l2_arbiter.sv
rtl/l2_axi_bridge.sv
sim_memory/axi_sim_memory.sv
rtl/l2_sim_top.sv
verification/l2_sim_checker.sv
verification/l2_sim_tb.sv

/* rtl/l2_arbiter.sv */
/*
 * one input slot per port, push only while full is low
 * a slot enters the queue one cycle after its grant
 */
`timescale 1ns/100ps
`include "l2_sim_params.svh"

module l2_arbiter (
    input  logic clk,
    input  logic rst,
    input  logic [29:0] req_addr [`L2_SIM_NUM_PORTS],
    input  logic [3:0] req_be [`L2_SIM_NUM_PORTS],
    input  logic req_rnw [`L2_SIM_NUM_PORTS],
    input  logic [31:0] req_wr_data [`L2_SIM_NUM_PORTS],
    input  l2_sim_pkg::l2_sub_id_t req_sub_id [`L2_SIM_NUM_PORTS],
    input  logic req_push [`L2_SIM_NUM_PORTS],
    output logic req_full [`L2_SIM_NUM_PORTS],
    output l2_sim_pkg::l2_request_t out_req,
    output logic out_valid,
    input  logic out_ready
);
    import l2_sim_pkg::*;

    localparam int NP = `L2_SIM_NUM_PORTS;
    localparam int QW = $clog2(`L2_SIM_REQ_DEPTH);

    logic [NP-1:0] slot_valid;
    l2_request_t   slot_req [NP];

    l2_port_t rr_ptr;
    logic     grant_req;
    l2_port_t grant_sel;
    logic     grant_valid;
    l2_port_t grant_port;

    l2_request_t   q_mem [`L2_SIM_REQ_DEPTH];
    logic [QW-1:0] wr_ptr;
    logic [QW-1:0] rd_ptr;
    logic [QW:0]   count;
    logic          pop;

    // full is simply the slot flag
    always_comb begin
        for (int p = 0; p < NP; p++) begin
            req_full[p] = slot_valid[p];
        end
    end

    ////////////////////
    // round-robin grant
    always_comb begin
        int idx;
        logic space_ok;
        grant_req = 1'b0;
        grant_sel = rr_ptr;
        // room must cover the move still in flight
        space_ok = (int'(count) + int'(grant_valid)) < `L2_SIM_REQ_DEPTH;
        // walk backwards so the port nearest rr_ptr wins
        for (int i = NP - 1; i >= 0; i--) begin
            idx = (int'(rr_ptr) + i) % NP;
            if (space_ok && slot_valid[idx] &&
                !(grant_valid && int'(grant_port) == idx)) begin
                grant_req = 1'b1;
                grant_sel = l2_port_t'(idx);
            end
        end
    end

    // control state
    always_ff @(posedge clk) begin
        if (rst) begin
            slot_valid  <= '0;
            rr_ptr      <= '0;
            grant_valid <= 1'b0;
            grant_port  <= '0;
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
        end else begin
            for (int p = 0; p < NP; p++) begin
                if (req_push[p] && !slot_valid[p]) begin
                    slot_valid[p] <= 1'b1;
                end
            end
            // granted slot drains into the queue this cycle
            if (grant_valid) begin
                slot_valid[grant_port] <= 1'b0;
                wr_ptr <= wr_ptr + 1'b1;
            end
            grant_valid <= grant_req;
            grant_port  <= grant_sel;
            if (grant_req) begin
                rr_ptr <= l2_port_t'((int'(grant_sel) + 1) % NP);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({grant_valid, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // payload, slots and queue entries
    always_ff @(posedge clk) begin
        for (int p = 0; p < NP; p++) begin
            if (req_push[p] && !slot_valid[p]) begin
                slot_req[p].op      <= req_rnw[p] ? L2_READ : L2_WRITE;
                slot_req[p].addr    <= req_addr[p];
                slot_req[p].be      <= req_be[p];
                slot_req[p].wr_data <= req_wr_data[p];
                slot_req[p].sub_id  <= req_sub_id[p];
                slot_req[p].port    <= l2_port_t'(p);
            end
        end
        if (grant_valid) begin
            q_mem[wr_ptr] <= slot_req[grant_port];
        end
    end

    assign out_valid = (count != '0);
    assign out_req   = q_mem[rd_ptr];
    assign pop       = out_valid && out_ready;

    ////////////////////
    // requester protocol
    for (genvar p = 0; p < NP; p++) begin : g_push_chk
        push_while_full : assert property (
            @(posedge clk) disable iff (rst) !(req_push[p] && req_full[p])
        ) else $error("port %0d pushed while full", p);
    end

endmodule

/* rtl/l2_axi_bridge.sv */
/*
 * one request in flight, reads block until rd_data_ack
 * writes are posted, b is consumed here and not reported
 */
`timescale 1ns/100ps
`include "l2_sim_params.svh"

module l2_axi_bridge (
    input  logic clk,
    input  logic rst,
    input  l2_sim_pkg::l2_request_t in_req,
    input  logic in_valid,
    output logic in_ready,
    l2_axi_if.master axi,
    output logic [31:0] rd_data,
    output l2_sim_pkg::l2_sub_id_t rd_sub_id,
    output l2_sim_pkg::l2_port_t rd_port,
    output logic rd_data_valid,
    input  logic rd_data_ack
);
    import l2_sim_pkg::*;

    bridge_state_t state;
    l2_request_t   cur_req;
    logic [31:0]   rd_data_q;
    logic          arvalid_q;
    logic          awvalid_q;
    logic          take;

    assign in_ready = (state == BR_IDLE);
    assign take     = in_valid && in_ready;

    ////////////////////
    // channel drive
    assign axi.araddr  = {cur_req.addr, 2'b00};
    assign axi.arvalid = arvalid_q;
    // no read data accepted once returning
    assign axi.rready  = (state == BR_READ);

    // aw and w always move together
    assign axi.awaddr  = {cur_req.addr, 2'b00};
    assign axi.awvalid = awvalid_q;
    assign axi.wdata   = cur_req.wr_data;
    assign axi.wstrb   = cur_req.be;
    assign axi.wvalid  = awvalid_q;
    assign axi.bready  = (state == BR_WRITE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= BR_IDLE;
            arvalid_q <= 1'b0;
            awvalid_q <= 1'b0;
        end else begin
            case (state)
                BR_IDLE: begin
                    if (take && in_req.op == L2_READ) begin
                        state     <= BR_READ;
                        arvalid_q <= 1'b1;
                    end else if (take) begin
                        state     <= BR_WRITE;
                        awvalid_q <= 1'b1;
                    end
                end
                BR_READ: begin
                    if (axi.arready) begin
                        arvalid_q <= 1'b0;
                    end
                    if (axi.rvalid) begin
                        state <= BR_RETURN;
                    end
                end
                BR_WRITE: begin
                    // memory takes aw and w in one cycle
                    if (axi.awready && axi.wready) begin
                        awvalid_q <= 1'b0;
                    end
                    if (axi.bvalid) begin
                        state <= BR_IDLE;
                    end
                end
                BR_RETURN: begin
                    // hold until the requester takes it, no timeout
                    if (rd_data_ack) begin
                        state <= BR_IDLE;
                    end
                end
                default: state <= BR_IDLE;
            endcase
        end
    end

    // payload capture
    always_ff @(posedge clk) begin
        if (take) begin
            cur_req <= in_req;
        end
        if (axi.rvalid && axi.rready) begin
            rd_data_q <= axi.rdata;
        end
    end

    ////////////////////
    // return port
    assign rd_data       = rd_data_q;
    assign rd_sub_id     = cur_req.sub_id;
    assign rd_port       = cur_req.port;
    assign rd_data_valid = (state == BR_RETURN);

    // memory must never answer a read we did not issue
    rvalid_in_read : assert property (
        @(posedge clk) disable iff (rst) axi.rvalid |-> state == BR_READ
    ) else $error("rvalid seen outside BR_READ");

endmodule

/* rtl/l2_sim_top.sv */
/*
 * two requester ports in, one tagged return port out
 * writes are posted, UART bytes appear on uart_write
 */
`timescale 1ns/100ps
`include "l2_sim_params.svh"

module l2_sim_top (
    input  logic clk,
    input  logic rst,
    // requester ports
    input  logic [29:0] req_addr [`L2_SIM_NUM_PORTS],
    input  logic [3:0] req_be [`L2_SIM_NUM_PORTS],
    input  logic req_rnw [`L2_SIM_NUM_PORTS],
    input  logic [31:0] req_wr_data [`L2_SIM_NUM_PORTS],
    input  l2_sim_pkg::l2_sub_id_t req_sub_id [`L2_SIM_NUM_PORTS],
    input  logic req_push [`L2_SIM_NUM_PORTS],
    output logic req_full [`L2_SIM_NUM_PORTS],
    // shared read return
    output logic [31:0] rd_data,
    output l2_sim_pkg::l2_sub_id_t rd_sub_id,
    output l2_sim_pkg::l2_port_t rd_port,
    output logic rd_data_valid,
    input  logic rd_data_ack,
    // console
    output logic uart_write,
    output logic [7:0] uart_byte
);
    import l2_sim_pkg::*;

    ////////////////////
    // stage links
    l2_request_t q_req;
    logic        q_valid;
    logic        q_ready;

    l2_axi_if axi_bus ();

    l2_arbiter arb0 (
        .clk         (clk),
        .rst         (rst),
        .req_addr    (req_addr),
        .req_be      (req_be),
        .req_rnw     (req_rnw),
        .req_wr_data (req_wr_data),
        .req_sub_id  (req_sub_id),
        .req_push    (req_push),
        .req_full    (req_full),
        .out_req     (q_req),
        .out_valid   (q_valid),
        .out_ready   (q_ready)
    );

    l2_axi_bridge bridge0 (
        .clk           (clk),
        .rst           (rst),
        .in_req        (q_req),
        .in_valid      (q_valid),
        .in_ready      (q_ready),
        .axi           (axi_bus.master),
        .rd_data       (rd_data),
        .rd_sub_id     (rd_sub_id),
        .rd_port       (rd_port),
        .rd_data_valid (rd_data_valid),
        .rd_data_ack   (rd_data_ack)
    );

    axi_sim_memory mem0 (
        .clk        (clk),
        .rst        (rst),
        .axi        (axi_bus.slave),
        .uart_write (uart_write),
        .uart_byte  (uart_byte)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the l2_sim testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f l2_sim.f --top-module l2_sim_tb -o l2_sim_tb

out=$(./obj_dir/l2_sim_tb)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'RESULT: PASS'; then
    exit 0
else
    exit 1
fi

/* sim_memory/axi_sim_memory.sv */
/*
 * one transaction at a time, fixed latencies, contents undefined until written
 * addresses wrap modulo the memory size, the UART word is not stored
 */
`timescale 1ns/100ps
`include "l2_sim_params.svh"

module axi_sim_memory (
    input  logic clk,
    input  logic rst,
    l2_axi_if.slave axi,
    output logic uart_write,
    output logic [7:0] uart_byte
);
    import l2_sim_pkg::*;

    localparam int MEM_AW = $clog2(`L2_SIM_MEM_WORDS);
    localparam int LAT_MAX = (`L2_SIM_READ_LATENCY > `L2_SIM_WRITE_LATENCY) ?
                             `L2_SIM_READ_LATENCY : `L2_SIM_WRITE_LATENCY;
    localparam int LAT_W = $clog2(LAT_MAX + 1);
    // counter ends at zero so the response lands latency+1 cycles out
    localparam logic [LAT_W-1:0] RD_LOAD = LAT_W'(`L2_SIM_READ_LATENCY - 1);
    localparam logic [LAT_W-1:0] WR_LOAD = LAT_W'(`L2_SIM_WRITE_LATENCY - 1);

    logic [31:0] mem_q [`L2_SIM_MEM_WORDS];

    mem_state_t        state;
    logic              is_read;
    logic [LAT_W-1:0]  lat_cnt;
    logic [31:0]       rdata_q;

    logic              r_accept;
    logic              w_accept;
    logic [MEM_AW-1:0] r_idx;
    logic [MEM_AW-1:0] w_idx;
    logic              r_is_uart;
    logic              w_is_uart;

    ////////////////////
    // acceptance
    // idle means ready, reads win a tie
    assign axi.arready = (state == MEM_IDLE);
    assign axi.awready = (state == MEM_IDLE) && !axi.arvalid;
    assign axi.wready  = (state == MEM_IDLE) && !axi.arvalid;

    assign r_accept = axi.arvalid && axi.arready;
    assign w_accept = axi.awvalid && axi.awready && axi.wvalid && axi.wready;

    // word index, upper address bits dropped
    assign r_idx     = axi.araddr[2 +: MEM_AW];
    assign w_idx     = axi.awaddr[2 +: MEM_AW];
    assign r_is_uart = (axi.araddr[31:2] == `L2_SIM_UART_ADDR);
    assign w_is_uart = (axi.awaddr[31:2] == `L2_SIM_UART_ADDR);

    ////////////////////
    // latency FSM
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= MEM_IDLE;
            is_read    <= 1'b0;
            lat_cnt    <= '0;
            uart_write <= 1'b0;
        end else begin
            // single pulse the cycle after the write is taken
            uart_write <= w_accept && w_is_uart;
            case (state)
                MEM_IDLE: begin
                    if (r_accept) begin
                        state   <= MEM_WAIT;
                        is_read <= 1'b1;
                        lat_cnt <= RD_LOAD;
                    end else if (w_accept) begin
                        state   <= MEM_WAIT;
                        is_read <= 1'b0;
                        lat_cnt <= WR_LOAD;
                    end
                end
                MEM_WAIT: begin
                    if (lat_cnt == '0) begin
                        state <= MEM_RESPOND;
                    end else begin
                        lat_cnt <= lat_cnt - 1'b1;
                    end
                end
                MEM_RESPOND: begin
                    // held until the bridge takes it
                    if ((is_read && axi.rready) || (!is_read && axi.bready)) begin
                        state <= MEM_IDLE;
                    end
                end
                default: state <= MEM_IDLE;
            endcase
        end
    end

    assign axi.rvalid = (state == MEM_RESPOND) && is_read;
    assign axi.bvalid = (state == MEM_RESPOND) && !is_read;
    assign axi.rdata  = rdata_q;

    ////////////////////
    // storage
    always_ff @(posedge clk) begin
        // read data sampled at acceptance
        if (r_accept) begin
            rdata_q <= r_is_uart ? 32'h0 : mem_q[r_idx];
        end
        if (w_accept && !w_is_uart) begin
            for (int b = 0; b < 4; b++) begin
                if (axi.wstrb[b]) begin
                    mem_q[w_idx][8*b +: 8] <= axi.wdata[8*b +: 8];
                end
            end
        end
        if (w_accept && w_is_uart) begin
            uart_byte <= axi.wdata[7:0];
        end
    end

    // bridge contract, aw and w are paired
    aw_w_paired : assert property (
        @(posedge clk) disable iff (rst) axi.awvalid == axi.wvalid
    ) else $error("awvalid and wvalid differ");

    // read answer arrives exactly latency+1 cycles after acceptance
    read_latency : assert property (
        @(posedge clk) disable iff (rst)
        r_accept |-> ##(`L2_SIM_READ_LATENCY + 1) axi.rvalid
    ) else $error("rvalid late or early");

endmodule

/* verification/l2_sim_checker.sv */
/*
 * watches the requester, return and UART ports of the DUT
 * reads are only predicted for words written earlier by the same port
 */
`timescale 1ns/100ps
`include "l2_sim_params.svh"

module l2_sim_checker (
    input  logic clk,
    input  logic rst,
    input  logic [29:0] req_addr [`L2_SIM_NUM_PORTS],
    input  logic [3:0] req_be [`L2_SIM_NUM_PORTS],
    input  logic req_rnw [`L2_SIM_NUM_PORTS],
    input  logic [31:0] req_wr_data [`L2_SIM_NUM_PORTS],
    input  l2_sim_pkg::l2_sub_id_t req_sub_id [`L2_SIM_NUM_PORTS],
    input  logic req_push [`L2_SIM_NUM_PORTS],
    input  logic req_full [`L2_SIM_NUM_PORTS],
    input  logic [31:0] rd_data,
    input  l2_sim_pkg::l2_sub_id_t rd_sub_id,
    input  l2_sim_pkg::l2_port_t rd_port,
    input  logic rd_data_valid,
    input  logic rd_data_ack,
    input  logic uart_write,
    input  logic [7:0] uart_byte,
    output int pending,
    output int err_count,
    output int check_count
);
    import l2_sim_pkg::*;

    logic [31:0] ref_mem [`L2_SIM_MEM_WORDS];
    // expected returns per port, sub-id above the data word
    logic [`L2_SIM_SUB_ID_W+31:0] exp_q [`L2_SIM_NUM_PORTS][$];
    logic [7:0] uart_q [$];
    int errs = 0;
    int checks = 0;
    logic hold_valid = 1'b0;
    logic [31:0] hold_data;

    // reference write, byte lanes picked by be
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] be);
        logic [31:0] word;
        word = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                word[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return word;
    endfunction

    ////////////////////
    // predict and compare
    always @(posedge clk) begin
        logic [`L2_SIM_SUB_ID_W+31:0] want;
        int idx;
        int sum;
        if (!rst) begin
            // accepted pushes update the model in port order
            for (int p = 0; p < `L2_SIM_NUM_PORTS; p++) begin
                idx = int'(req_addr[p] % `L2_SIM_MEM_WORDS);
                if (req_push[p] && !req_full[p]) begin
                    if (req_addr[p] == `L2_SIM_UART_ADDR && !req_rnw[p]) begin
                        uart_q.push_back(req_wr_data[p][7:0]);
                    end else if (!req_rnw[p]) begin
                        ref_mem[idx] = merge_bytes(ref_mem[idx], req_wr_data[p], req_be[p]);
                    end else if (req_addr[p] == `L2_SIM_UART_ADDR) begin
                        exp_q[p].push_back({req_sub_id[p], 32'h0});
                    end else begin
                        exp_q[p].push_back({req_sub_id[p], ref_mem[idx]});
                    end
                end
            end
            // data must hold until acked
            if (hold_valid && rd_data_valid && rd_data !== hold_data) begin
                $display("error rd_data changed while valid: was %h now %h", hold_data, rd_data);
                errs++;
            end
            hold_valid = rd_data_valid && !rd_data_ack;
            hold_data  = rd_data;
            if (rd_data_valid && rd_data_ack) begin
                checks++;
                if (exp_q[rd_port].size() == 0) begin
                    $display("read return on port %0d with no read outstanding", rd_port);
                    errs++;
                end else begin
                    want = exp_q[rd_port].pop_front();
                    if (rd_data !== want[31:0]) begin
                        $display("error rd_data port %0d: got %h expected %h",
                                 rd_port, rd_data, want[31:0]);
                        errs++;
                    end
                    if (rd_sub_id !== want[`L2_SIM_SUB_ID_W+31:32]) begin
                        $display("error rd_sub_id port %0d: got %h expected %h",
                                 rd_port, rd_sub_id, want[`L2_SIM_SUB_ID_W+31:32]);
                        errs++;
                    end
                end
            end
            // console bytes in write order
            if (uart_write) begin
                checks++;
                if (uart_q.size() == 0) begin
                    $display("uart write seen with no byte expected");
                    errs++;
                end else if (uart_byte !== uart_q[0]) begin
                    $display("error uart_byte: got %h expected %h", uart_byte, uart_q[0]);
                    errs++;
                    void'(uart_q.pop_front());
                end else begin
                    void'(uart_q.pop_front());
                end
            end
        end
        sum = uart_q.size();
        for (int p = 0; p < `L2_SIM_NUM_PORTS; p++) begin
            sum += exp_q[p].size();
        end
        pending     <= sum;
        err_count   <= errs;
        check_count <= checks;
    end

endmodule

/* verification/l2_sim_tb.sv */
/*
 * drives both requester ports, acks returns after a random hold
 * every wait gives up after TIMEOUT cycles and marks the run aborted
 */
`timescale 1ns/100ps
`include "l2_sim_params.svh"

module l2_sim_tb;
    import l2_sim_pkg::*;

    localparam int NP = `L2_SIM_NUM_PORTS;
    localparam int TIMEOUT = 2000;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic [29:0] req_addr [NP];
    logic [3:0] req_be [NP];
    logic req_rnw [NP];
    logic [31:0] req_wr_data [NP];
    l2_sub_id_t req_sub_id [NP];
    logic req_push [NP];
    logic req_full [NP];
    logic [31:0] rd_data;
    l2_sub_id_t rd_sub_id;
    l2_port_t rd_port;
    logic rd_data_valid;
    logic rd_data_ack = 1'b0;
    logic uart_write;
    logic [7:0] uart_byte;
    int pending;
    int err_count;
    int check_count;

    integer seed = 13;
    int tb_errs = 0;
    int errs_before = 0;
    int tests_run = 0;
    int ack_max = 0;
    int ack_delay = 0;
    int max_wait = 0;
    bit aborted = 1'b0;
    bit written [`L2_SIM_MEM_WORDS];

    l2_sim_top dut0 (.*);

    l2_sim_checker chk0 (.*);

    // 40 ns period
    always #20 clk = ~clk;

    ////////////////////
    // return acknowledge, held off for 0..ack_max cycles
    always @(posedge clk) begin
        if (rst) begin
            rd_data_ack <= 1'b0;
        end else if (rd_data_ack) begin
            rd_data_ack <= 1'b0;
        end else if (rd_data_valid && ack_delay == 0) begin
            rd_data_ack <= 1'b1;
            ack_delay   <= int'({$random(seed)} % (ack_max + 1));
        end else if (rd_data_valid) begin
            ack_delay <= ack_delay - 1;
        end
    end

    // one push, waits for full to drop first
    task automatic push_req(input int p, input logic rnw, input logic [29:0] addr,
                            input logic [3:0] be, input logic [31:0] data, input int sub);
        int n;
        if (aborted) return;
        n = 0;
        @(posedge clk);
        while (req_full[p] && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (n > max_wait) max_wait = n;
        if (n >= TIMEOUT) begin
            $display("push on port %0d timed out, req_full never dropped", p);
            aborted = 1'b1;
        end else begin
            req_addr[p]    <= addr;
            req_be[p]      <= be;
            req_rnw[p]     <= rnw;
            req_wr_data[p] <= data;
            req_sub_id[p]  <= l2_sub_id_t'(sub);
            req_push[p]    <= 1'b1;
            @(posedge clk);
            req_push[p]    <= 1'b0;
        end
    endtask

    // all predicted returns and UART bytes seen
    task automatic wait_drain();
        int n;
        if (aborted) return;
        n = 0;
        @(posedge clk);
        while (pending != 0 && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (n >= TIMEOUT) begin
            $display("timed out with %0d responses still missing", pending);
            aborted = 1'b1;
        end
    endtask

    task automatic end_test(input string name);
        int errs_now;
        errs_now = err_count + tb_errs;
        tests_run++;
        $display("test %0d %s: %0d errors", tests_run, name, errs_now - errs_before);
        errs_before = errs_now;
    endtask

    // reads only hit words this port already wrote
    task automatic random_traffic(input int p, input int base);
        int a;
        logic [31:0] d;
        logic rnw;
        for (int i = 0; i < 12; i++) begin
            a   = base + int'({$random(seed)} % 8);
            d   = $random(seed);
            rnw = d[31] && written[a];
            push_req(p, rnw, 30'(a), 4'hf, d, i % 4);
            if (!rnw) written[a] = 1'b1;
        end
    endtask

    ////////////////////
    // test sequence
    initial begin
        for (int p = 0; p < NP; p++) begin
            req_addr[p]    = '0;
            req_be[p]      = '0;
            req_rnw[p]     = 1'b0;
            req_wr_data[p] = '0;
            req_sub_id[p]  = '0;
            req_push[p]    = 1'b0;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < 4; i++) push_req(0, 1'b0, 30'(i), 4'hf, $random(seed), 0);
        for (int i = 0; i < 4; i++) push_req(0, 1'b1, 30'(i), 4'hf, 32'h0, i);
        wait_drain();
        end_test("full word write and read");

        // full word first, then a partial overwrite
        for (int i = 4; i < 8; i++) begin
            push_req(0, 1'b0, 30'(i), 4'hf, $random(seed), 0);
            push_req(0, 1'b0, 30'(i), 4'(i + 1), $random(seed), 0);
            push_req(0, 1'b1, 30'(i), 4'hf, 32'h0, i % 4);
        end
        wait_drain();
        if (!aborted) end_test("byte enable merge");

        fork
            random_traffic(0, 32);
            random_traffic(1, 160);
        join
        wait_drain();
        if (!aborted) end_test("two port random");

        ack_max  = 40;
        max_wait = 0;
        for (int i = 0; i < 8; i++) push_req(0, 1'b1, 30'(i), 4'hf, 32'h0, i % 4);
        wait_drain();
        ack_max = 0;
        if (!aborted && max_wait < 8) begin
            $display("req_full never held a push back while returns stalled");
            tb_errs++;
        end
        if (!aborted) end_test("stalled return");

        // upper bytes must not reach the console
        push_req(0, 1'b0, `L2_SIM_UART_ADDR, 4'hf, 32'ha5a5a548, 0);
        push_req(0, 1'b0, `L2_SIM_UART_ADDR, 4'hf, 32'h5a5a5a69, 0);
        push_req(0, 1'b0, `L2_SIM_UART_ADDR, 4'hf, 32'hffffff0a, 0);
        push_req(0, 1'b1, `L2_SIM_UART_ADDR, 4'hf, 32'h0, 3);
        wait_drain();
        if (!aborted) end_test("uart capture");

        push_req(1, 1'b0, 30'h30, 4'hf, 32'hcafe0130, 0);
        push_req(1, 1'b1, 30'h130, 4'hf, 32'h0, 1);
        push_req(1, 1'b1, 30'h230, 4'hf, 32'h0, 2);
        wait_drain();
        if (!aborted) end_test("address wrap");

        $display("tests %0d, checks %0d, errors %0d", tests_run, check_count,
                 err_count + tb_errs);
        if (!aborted && err_count + tb_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
